// File: Makefile
# Verilator build and run for the host domain

VERILATOR ?= verilator
TOP       ?= tb_host_domain
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "Variables: VERILATOR TOP LOG BUILD_DIR PASS_MSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f sim.f
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hw/host_defines.svh
// Host domain parameters
`ifndef HOST_DEFINES_SVH
`define HOST_DEFINES_SVH

// L2 geometry
`define HOST_NB_L2_BANKS    8
`define HOST_L2_BANK_WORDS  256

// Bus and counter widths
`define HOST_DATA_WIDTH     32
`define HOST_ADDR_WIDTH     32
`define HOST_COUNT_WIDTH    32

// Word index inside the byte address, bank bits first, then row bits
`define HOST_WORD_LSB       2
`define HOST_WORD_MSB       12

// Byte-address bit splitting L2 from configuration space
`define HOST_REGION_BIT     16

// Configuration word offsets
`define HOST_CFG_RD_COUNT   0
`define HOST_CFG_WR_COUNT   1
`define HOST_CFG_CLEAR      2

// Read value of every other configuration word
`define HOST_CFG_UNMAPPED   32'hDEADF000

`endif

// File: hw/host_domain.sv
// Host L2 memory domain
`timescale 1ns/1ps

module host_domain import host_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      cyc_i,
  input  logic      stb_i,
  input  logic      we_i,
  input  addr_t     adr_i,
  input  word_t     dat_i,
  input  byte_sel_t sel_i,
  output word_t     dat_o,
  output logic      ack_o
);

  // Control to banks
  logic      bank_en;
  logic      bank_we;
  bank_idx_t bank_idx;
  bank_row_t bank_row;
  byte_sel_t bank_sel;
  word_t     bank_wdata;
  word_t     bank_rdata;

  // Control to counters
  logic      rd_evt;
  logic      wr_evt;
  logic      cnt_clr;
  count_t    rd_count;
  count_t    wr_count;

  l2_bus_fsm i_l2_bus_fsm (
    .clk_i        ( clk_i      ),
    .rst_i        ( rst_i      ),
    .cyc_i        ( cyc_i      ),
    .stb_i        ( stb_i      ),
    .we_i         ( we_i       ),
    .adr_i        ( adr_i      ),
    .dat_i        ( dat_i      ),
    .sel_i        ( sel_i      ),
    .ack_o        ( ack_o      ),
    .dat_o        ( dat_o      ),
    .bank_en_o    ( bank_en    ),
    .bank_we_o    ( bank_we    ),
    .bank_idx_o   ( bank_idx   ),
    .bank_row_o   ( bank_row   ),
    .bank_sel_o   ( bank_sel   ),
    .bank_wdata_o ( bank_wdata ),
    .rdata_i      ( bank_rdata ),
    .rd_evt_o     ( rd_evt     ),
    .wr_evt_o     ( wr_evt     ),
    .clr_o        ( cnt_clr    ),
    .rd_count_i   ( rd_count   ),
    .wr_count_i   ( wr_count   )
  );

  l2_bank_array i_l2_bank_array (
    .clk_i        ( clk_i      ),
    .bank_en_i    ( bank_en    ),
    .bank_we_i    ( bank_we    ),
    .bank_idx_i   ( bank_idx   ),
    .bank_row_i   ( bank_row   ),
    .bank_sel_i   ( bank_sel   ),
    .bank_wdata_i ( bank_wdata ),
    .rdata_o      ( bank_rdata )
  );

  l2_event_counters i_l2_event_counters (
    .clk_i        ( clk_i      ),
    .rst_i        ( rst_i      ),
    .rd_evt_i     ( rd_evt     ),
    .wr_evt_i     ( wr_evt     ),
    .clr_i        ( cnt_clr    ),
    .rd_count_o   ( rd_count   ),
    .wr_count_o   ( wr_count   )
  );

endmodule

// File: hw/host_pkg.sv
// Host domain types
`include "host_defines.svh"

package host_pkg;

  // Bus payload
  typedef logic [`HOST_DATA_WIDTH-1:0]   word_t;
  typedef logic [`HOST_ADDR_WIDTH-1:0]   addr_t;
  typedef logic [`HOST_DATA_WIDTH/8-1:0] byte_sel_t;

  // L2 addressing
  typedef logic [$clog2(`HOST_NB_L2_BANKS)-1:0]   bank_idx_t;
  typedef logic [$clog2(`HOST_L2_BANK_WORDS)-1:0] bank_row_t;

  // Word index, also used as configuration word offset
  typedef logic [`HOST_WORD_MSB-`HOST_WORD_LSB:0] word_idx_t;

  // Event counters
  typedef logic [`HOST_COUNT_WIDTH-1:0] count_t;

  // Wishbone slave sequence
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ACCESS,
    ST_ACK
  } bus_state_e;

endpackage

// File: hw/l2_bank_array.sv
// Word-interleaved L2 banks
`timescale 1ns/1ps
`include "host_defines.svh"

module l2_bank_array import host_pkg::*; (
  input  logic      clk_i,
  input  logic      bank_en_i,
  input  logic      bank_we_i,
  input  bank_idx_t bank_idx_i,
  input  bank_row_t bank_row_i,
  input  byte_sel_t bank_sel_i,
  input  word_t     bank_wdata_i,
  output word_t     rdata_o
);

  word_t     bank_rdata [`HOST_NB_L2_BANKS];
  bank_idx_t rd_bank_q;

  // Bank that answers in the next cycle
  always_ff @(posedge clk_i) begin
    if (bank_en_i) begin
      rd_bank_q <= bank_idx_i;
    end
  end

  for (genvar g = 0; g < `HOST_NB_L2_BANKS; g++) begin : gen_bank
    word_t mem [`HOST_L2_BANK_WORDS];
    word_t rdata_q;
    logic  bank_hit;

    assign bank_hit = bank_en_i && (bank_idx_i == bank_idx_t'(g));

    always_ff @(posedge clk_i) begin
      if (bank_hit) begin
        if (bank_we_i) begin
          // Byte lanes not selected keep their old value
          for (int b = 0; b < $bits(byte_sel_t); b++) begin
            if (bank_sel_i[b]) begin
              mem[bank_row_i][8*b +: 8] <= bank_wdata_i[8*b +: 8];
            end
          end
        end else begin
          rdata_q <= mem[bank_row_i];
        end
      end
    end

    assign bank_rdata[g] = rdata_q;
  end

  assign rdata_o = bank_rdata[rd_bank_q];

  a_we_needs_en: assert property (
    @(posedge clk_i) bank_we_i |-> bank_en_i
  );

endmodule

// File: hw/l2_bus_fsm.sv
// L2 Wishbone slave control
`timescale 1ns/1ps
`include "host_defines.svh"

module l2_bus_fsm import host_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  // Wishbone classic slave
  input  logic      cyc_i,
  input  logic      stb_i,
  input  logic      we_i,
  input  addr_t     adr_i,
  input  word_t     dat_i,
  input  byte_sel_t sel_i,
  output logic      ack_o,
  output word_t     dat_o,
  // Bank array side
  output logic      bank_en_o,
  output logic      bank_we_o,
  output bank_idx_t bank_idx_o,
  output bank_row_t bank_row_o,
  output byte_sel_t bank_sel_o,
  output word_t     bank_wdata_o,
  input  word_t     rdata_i,
  // Event counter side
  output logic      rd_evt_o,
  output logic      wr_evt_o,
  output logic      clr_o,
  input  count_t    rd_count_i,
  input  count_t    wr_count_i
);

  bus_state_e state_q;
  bus_state_e state_d;
  logic       ack_q;
  logic       req;
  logic       is_cfg;
  logic       in_ack;
  word_idx_t  word_idx;
  word_t      cfg_rdata;

  // Old request is still on the bus during the ack cycle
  assign req      = cyc_i && stb_i && !ack_q;
  assign is_cfg   = adr_i[`HOST_REGION_BIT];
  assign word_idx = adr_i[`HOST_WORD_MSB:`HOST_WORD_LSB];
  assign in_ack   = (state_q == ST_ACK);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:   if (req) state_d = ST_ACCESS;
      ST_ACCESS: state_d = ST_ACK;
      ST_ACK:    state_d = ST_IDLE;
      default:   state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
      ack_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      ack_q   <= in_ack;
    end
  end

  // Low bits pick the bank, so consecutive words spread over all banks
  assign {bank_row_o, bank_idx_o} = word_idx;
  assign bank_en_o    = (state_q == ST_ACCESS) && !is_cfg;
  assign bank_we_o    = bank_en_o && we_i;
  assign bank_sel_o   = sel_i;
  assign bank_wdata_o = dat_i;

  always_comb begin
    case (word_idx)
      word_idx_t'(`HOST_CFG_RD_COUNT): cfg_rdata = rd_count_i;
      word_idx_t'(`HOST_CFG_WR_COUNT): cfg_rdata = wr_count_i;
      default:                         cfg_rdata = `HOST_CFG_UNMAPPED;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (in_ack) begin
      dat_o <= is_cfg ? cfg_rdata : rdata_i;
    end
  end

  assign ack_o = ack_q;

  // Only L2 traffic is counted
  assign rd_evt_o = in_ack && !is_cfg && !we_i;
  assign wr_evt_o = in_ack && !is_cfg && we_i;
  assign clr_o    = in_ack && is_cfg && we_i && (word_idx == word_idx_t'(`HOST_CFG_CLEAR));

  a_ack_with_stb: assert property (
    @(posedge clk_i) disable iff (rst_i) ack_o |-> stb_i
  );

  a_ack_single: assert property (
    @(posedge clk_i) disable iff (rst_i) ack_o |=> !ack_o
  );

endmodule

// File: hw/l2_event_counters.sv
// L2 access event counters
`timescale 1ns/1ps

module l2_event_counters import host_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_i,
  input  logic   rd_evt_i,
  input  logic   wr_evt_i,
  input  logic   clr_i,
  output count_t rd_count_o,
  output count_t wr_count_o
);

  // Entry 0 counts reads, entry 1 counts writes
  logic [1:0] evt;
  count_t     count_q [2];

  assign evt = {wr_evt_i, rd_evt_i};

  // Clear wins over a same-cycle increment
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < 2; i++) begin
      if (rst_i || clr_i) begin
        count_q[i] <= '0;
      end else if (evt[i]) begin
        count_q[i] <= count_q[i] + count_t'(1);
      end
    end
  end

  assign rd_count_o = count_q[0];
  assign wr_count_o = count_q[1];

  a_evt_exclusive: assert property (
    @(posedge clk_i) disable iff (rst_i) !(rd_evt_i && wr_evt_i)
  );

endmodule

// File: sim.f
+incdir+hw
hw/host_pkg.sv
hw/l2_bus_fsm.sv
hw/l2_bank_array.sv
hw/l2_event_counters.sv
hw/host_domain.sv
verification/host_domain_checker.sv
verification/tb_host_domain.sv

// File: verification/host_domain_checker.sv
// Wishbone response checker
`timescale 1ns/1ps

module host_domain_checker import host_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  cyc_i,
  input  logic  stb_i,
  input  logic  ack_i,
  input  addr_t adr_i,
  input  word_t dat_i,
  input  logic  check_en_i,
  input  word_t exp_data_i,
  output int    err_count_o,
  output int    check_count_o
);

  // Edges seen since the request was sampled, 0 when idle
  int phase = 0;
  int err_count = 0;
  int check_count = 0;

  task automatic expect_ack(input logic exp_ack);
    if (ack_i !== exp_ack) begin
      $display("ERR ack_o: got %h expected %h at %0t", ack_i, exp_ack, $time);
      err_count++;
    end
  endtask

  task automatic compare_data();
    check_count++;
    if (dat_i !== exp_data_i) begin
      $display("ERR dat_o: got %h expected %h (adr_i %h) at %0t",
               dat_i, exp_data_i, adr_i, $time);
      err_count++;
    end
  endtask

  // Ack must come exactly in the third cycle after the sampled request
  always @(posedge clk_i) begin
    if (rst_i) begin
      phase = 0;
    end else begin
      case (phase)
        0: begin
          expect_ack(1'b0);
          if (cyc_i && stb_i) begin
            phase = 1;
          end
        end
        1, 2: begin
          expect_ack(1'b0);
          phase = phase + 1;
        end
        default: begin
          expect_ack(1'b1);
          if (ack_i === 1'b1 && check_en_i) begin
            compare_data();
          end
          phase = 0;
        end
      endcase
    end
  end

  assign err_count_o   = err_count;
  assign check_count_o = check_count;

endmodule

// File: verification/host_patterns.txt
# op addr data sel expected, all hex except op (R or W)
# expected is compared for reads only
# One word per bank, row 0
W 00000000 11111111 f 00000000
W 00000004 22222222 f 00000000
W 00000008 33333333 f 00000000
W 0000000c 44444444 f 00000000
W 00000010 55555555 f 00000000
W 00000014 66666666 f 00000000
W 00000018 77777777 f 00000000
W 0000001c 88888888 f 00000000
R 00000000 00000000 f 11111111
R 00000004 00000000 f 22222222
R 00000008 00000000 f 33333333
R 0000000c 00000000 f 44444444
R 00000010 00000000 f 55555555
R 00000014 00000000 f 66666666
R 00000018 00000000 f 77777777
R 0000001c 00000000 f 88888888
# Bit 14 aliases onto word 2
W 00004008 a5a5a5a5 f 00000000
R 00000008 00000000 f a5a5a5a5
# Partial byte writes
W 00000124 cafebabe f 00000000
W 00000124 00112233 5 00000000
R 00000124 00000000 f ca11ba33
W 00000124 44556677 8 00000000
R 00000124 00000000 f 4411ba33
W 0000001c 9999aaaa 3 00000000
R 0000001c 00000000 f 8888aaaa
# Counters: 12 L2 reads, 13 L2 writes so far
R 00010000 00000000 f 0000000c
R 00010004 00000000 f 0000000d
R 0001000c 00000000 f deadf000
W 00010004 ffffffff f 00000000
R 00010004 00000000 f 0000000d
# Clear both counters
W 00010008 00000000 f 00000000
R 00010000 00000000 f 00000000
R 00010004 00000000 f 00000000
# Bit 17 is ignored as well
W 00000040 0badf00d f 00000000
R 00000040 00000000 f 0badf00d
R 00020040 00000000 f 0badf00d
R 00000000 00000000 f 11111111
R 00010000 00000000 f 00000003
R 00010004 00000000 f 00000001
R 0001001c 00000000 f deadf000

// File: verification/tb_host_domain.sv
// Host domain testbench
`timescale 1ns/1ps

module tb_host_domain import host_pkg::*; ();

  localparam int    CLK_PERIOD   = 100;
  localparam int    ACK_LIMIT    = 8;
  localparam string PATTERN_FILE = "verification/host_patterns.txt";

  logic      clk;
  logic      rst;
  logic      cyc;
  logic      stb;
  logic      we;
  addr_t     adr;
  word_t     dat_w;
  byte_sel_t sel;
  word_t     dat_r;
  logic      ack;

  // Checker side
  logic      check_en;
  word_t     exp_data;
  int        chk_errors;
  int        chk_count;

  // Pattern table
  logic      pat_we  [$];
  addr_t     pat_adr [$];
  word_t     pat_dat [$];
  byte_sel_t pat_sel [$];
  word_t     pat_exp [$];

  logic        loaded = 1'b0;
  int          tb_errors = 0;
  logic [31:0] lcg_state = 32'he9a7;

  host_domain i_host_domain (
    .clk_i ( clk   ),
    .rst_i ( rst   ),
    .cyc_i ( cyc   ),
    .stb_i ( stb   ),
    .we_i  ( we    ),
    .adr_i ( adr   ),
    .dat_i ( dat_w ),
    .sel_i ( sel   ),
    .dat_o ( dat_r ),
    .ack_o ( ack   )
  );

  host_domain_checker i_host_domain_checker (
    .clk_i         ( clk        ),
    .rst_i         ( rst        ),
    .cyc_i         ( cyc        ),
    .stb_i         ( stb        ),
    .ack_i         ( ack        ),
    .adr_i         ( adr        ),
    .dat_i         ( dat_r      ),
    .check_en_i    ( check_en   ),
    .exp_data_i    ( exp_data   ),
    .err_count_o   ( chk_errors ),
    .check_count_o ( chk_count  )
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic load_patterns();
    int    fd;
    int    n;
    string line;
    byte   op;
    addr_t a;
    word_t d;
    word_t e;
    byte_sel_t s;
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
      $display("Could not open pattern file %s", PATTERN_FILE);
      tb_errors++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 3 || line.getc(0) == "#") begin
        continue;
      end
      op = line.getc(0);
      n = $sscanf(line.substr(2, line.len() - 1), "%h %h %h %h", a, d, s, e);
      if ((op != "R" && op != "W") || n != 4) begin
        $display("Malformed pattern line: %s", line);
        tb_errors++;
        continue;
      end
      pat_we.push_back(op == "W");
      pat_adr.push_back(a);
      pat_dat.push_back(d);
      pat_sel.push_back(s);
      pat_exp.push_back(e);
    end
    $fclose(fd);
  endtask

  // One Wishbone classic cycle, stb held until the edge that ends the ack
  task automatic run_access(input int idx);
    int wait_cycles;
    wait_cycles = 0;
    cyc      = 1'b1;
    stb      = 1'b1;
    we       = pat_we[idx];
    adr      = pat_adr[idx];
    dat_w    = pat_dat[idx];
    sel      = pat_sel[idx];
    exp_data = pat_exp[idx];
    check_en = !pat_we[idx];
    @(negedge clk);
    while (ack !== 1'b1 && wait_cycles < ACK_LIMIT) begin
      @(negedge clk);
      wait_cycles++;
    end
    if (ack !== 1'b1) begin
      $display("No acknowledge for access %0d within %0d cycles", idx, ACK_LIMIT);
      tb_errors++;
    end
    @(negedge clk);
    cyc      = 1'b0;
    stb      = 1'b0;
    we       = 1'b0;
    check_en = 1'b0;
  endtask

  initial begin
    logic [1:0] gap;
    cyc      = 1'b0;
    stb      = 1'b0;
    we       = 1'b0;
    adr      = '0;
    dat_w    = '0;
    sel      = '0;
    exp_data = '0;
    check_en = 1'b0;
    rst      = 1'b1;
    load_patterns();
    if (pat_we.size() == 0) begin
      $display("No patterns were loaded");
      tb_errors++;
    end
    loaded = 1'b1;
    // Two rising edges in reset, release on the falling edge after them
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < pat_we.size(); i++) begin
      lcg_state = lcg_next(lcg_state);
      gap = lcg_state[17:16];
      repeat (gap) @(negedge clk);
      run_access(i);
    end
    repeat (2) @(negedge clk);
    $display("Accesses: %0d  read checks: %0d  checker errors: %0d  testbench errors: %0d",
             pat_we.size(), chk_count, chk_errors, tb_errors);
    if (chk_errors == 0 && tb_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Eight cycles per access at most, plus margin for reset
  initial begin
    int limit_ns;
    wait (loaded);
    limit_ns = pat_we.size() * 8 * CLK_PERIOD + 2000;
    #(limit_ns);
    $display("Timeout: run did not complete within %0d ns", limit_ns);
    $display("Done: errors found");
    $finish;
  end

endmodule
